//--- src/huff_mem_pkg.sv
package huff_mem_pkg;

    localparam int unsigned char_w    = 8;     // one input character
    localparam int unsigned word_w    = 32;    // sram word, count or code word
    localparam int unsigned addr_w    = 12;    // byte address into the sram
    localparam int unsigned mem_depth = 1024;  // words, so 4 KB of byte space

    // region bases in byte space, 256 chars x 4 bytes each
    localparam logic [addr_w-1:0] hist_base = 12'd0;     // frequency counts
    localparam logic [addr_w-1:0] cb_base   = 12'd1024;  // code words

    // sequencer access phases
    typedef enum logic [2:0] {
        IDLE,       // waiting for a request
        READ,       // r_en strobe
        WRITE,      // wr_en strobe
        WAITREAD,   // sram output settles
        WAITWRITE,  // write lands
        DONE_R,     // capture rdata
        DONE_WR     // write finished
    } seq_state_e;

    // owner of the access in flight, also picks the region base
    typedef enum logic [1:0] {
        CL_NONE,    // no access in flight
        CL_HIST,    // histogram block
        CL_CB       // codebook block
    } client_e;

    // histogram opcodes
    typedef enum logic [1:0] {
        HOP_COUNT,  // read, add one with saturation, write back
        HOP_READ,   // read only
        HOP_CLEAR   // write zero
    } hist_op_e;

endpackage

//--- src/mem_client_if.sv
`timescale 1ns/10ps

// one client's path into the sram sequencer
interface mem_client_if import huff_mem_pkg::*; ();

    logic              req;    // level, held until done
    logic              we;     // 1 write, 0 read
    logic [char_w-1:0] index;  // character, scaled to a byte address by the server
    logic [word_w-1:0] wdata;  // write payload
    logic [word_w-1:0] rdata;  // read result, valid with done
    logic              done;   // one cycle, ends the access

    modport client (
        output req, we, index, wdata,
        input  rdata, done
    );

    modport server (
        input  req, we, index, wdata,
        output rdata, done
    );

endinterface

//--- src/sram_bus_if.sv
`timescale 1ns/10ps

// sequencer to sram model
interface sram_bus_if import huff_mem_pkg::*; ();

    logic [addr_w-1:0] addr;   // byte address, low two bits ignored
    logic [word_w-1:0] wdata;  // write data
    logic              r_en;   // one cycle read strobe
    logic              wr_en;  // one cycle write strobe
    logic [word_w-1:0] rdata;  // registered read data

    modport controller (
        output addr, wdata, r_en, wr_en,
        input  rdata
    );

    modport memory (
        input  addr, wdata, r_en, wr_en,
        output rdata
    );

endinterface

//--- src/sram_model.sv
`timescale 1ns/10ps

module sram_model import huff_mem_pkg::*; (
    input logic        clk,
    input logic        rst,
    sram_bus_if.memory bus
);

    logic [word_w-1:0]   mem [mem_depth];  // word array
    logic [addr_w-3:0]   word_idx;         // byte address over four

    assign word_idx = bus.addr[addr_w-1:2];  // drop byte offset

    // write lands at the edge that samples wr_en
    always_ff @(posedge clk) begin
        if (bus.wr_en) begin
            mem[word_idx] <= bus.wdata;
        end
    end

    // read data is registered and holds until the next read
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            bus.rdata <= '0;
        end else if (bus.r_en) begin
            bus.rdata <= mem[word_idx];  // valid from the cycle after r_en
        end
    end

endmodule

//--- src/sram_sequencer.sv
`timescale 1ns/10ps

module sram_sequencer import huff_mem_pkg::*; (
    input logic           clk,
    input logic           rst,
    mem_client_if.server  hist_mem,
    mem_client_if.server  cb_mem,
    sram_bus_if.controller bus
);

    seq_state_e        state;      // access phase
    seq_state_e        next_state;
    client_e           owner;      // who owns the access in flight
    client_e           sel;        // arbitration result in IDLE
    logic              sel_we;     // write request from the winner
    logic              grant_ok;   // no done pulse on the wires
    logic [addr_w-1:0] base;       // region base of the owner
    logic [char_w-1:0] idx;        // owner's character
    logic [word_w-1:0] rdata_q;    // captured read result
    logic              hist_done_q;
    logic              cb_done_q;

    // a done pulse means the client still holds req this cycle, so skip it
    assign grant_ok = !hist_mem.done && !cb_mem.done;

    // fixed priority, histogram first
    always_comb begin
        if (!grant_ok) begin
            sel = CL_NONE;
        end else if (hist_mem.req) begin
            sel = CL_HIST;
        end else if (cb_mem.req) begin
            sel = CL_CB;
        end else begin
            sel = CL_NONE;
        end
        sel_we = (sel == CL_CB) ? cb_mem.we : hist_mem.we;
    end

    // owner picks base, index and write data
    always_comb begin
        case (owner)
            CL_CB: begin
                base      = cb_base;
                idx       = cb_mem.index;
                bus.wdata = cb_mem.wdata;
            end
            default: begin
                base      = hist_base;  // CL_NONE lands here too, no strobe then
                idx       = hist_mem.index;
                bus.wdata = hist_mem.wdata;
            end
        endcase
    end

    // base plus four times index
    assign bus.addr  = base + {{(addr_w-char_w-2){1'b0}}, idx, 2'b00};
    assign bus.r_en  = (state == READ);
    assign bus.wr_en = (state == WRITE);

    always_comb begin
        next_state = state;
        case (state)
            IDLE: begin
                if (sel != CL_NONE) begin
                    next_state = sel_we ? WRITE : READ;
                end
            end
            READ:      next_state = WAITREAD;
            WRITE:     next_state = WAITWRITE;
            WAITREAD:  next_state = DONE_R;
            WAITWRITE: next_state = DONE_WR;
            DONE_R:    next_state = IDLE;
            DONE_WR:   next_state = IDLE;
            default:   next_state = IDLE;
        endcase
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state       <= IDLE;
            owner       <= CL_NONE;
            hist_done_q <= 1'b0;
            cb_done_q   <= 1'b0;
        end else begin
            state       <= next_state;
            hist_done_q <= 1'b0;  // pulses only
            cb_done_q   <= 1'b0;
            if (state == IDLE && sel != CL_NONE) begin
                owner <= sel;  // captured with the request
            end
            if (state == DONE_R || state == DONE_WR) begin
                hist_done_q <= (owner == CL_HIST);  // only the owner hears done
                cb_done_q   <= (owner == CL_CB);
                owner       <= CL_NONE;
            end
        end
    end

    // rdata is stable since the cycle after READ
    always_ff @(posedge clk) begin
        if (state == DONE_R) begin
            rdata_q <= bus.rdata;
        end
    end

    assign hist_mem.rdata = rdata_q;  // only meaningful with the owner's done
    assign cb_mem.rdata   = rdata_q;
    assign hist_mem.done  = hist_done_q;
    assign cb_mem.done    = cb_done_q;

endmodule

//--- src/histogram_counter.sv
`timescale 1ns/10ps

module histogram_counter import huff_mem_pkg::*; (
    input  logic              clk,
    input  logic              rst,
    input  logic              hist_valid,  // strobe, taken while hist_ready
    input  hist_op_e          hist_op,
    input  logic [char_w-1:0] hist_char,
    output logic              hist_ready,
    output logic              hist_done,   // one cycle, hist_count valid
    output logic [word_w-1:0] hist_count,
    mem_client_if.client      mem
);

    typedef enum logic [1:0] {
        H_IDLE,  // ready for a strobe
        H_RD,    // read access in flight
        H_WR,    // write access in flight
        H_DONE   // report
    } hist_state_e;

    hist_state_e       state;
    hist_op_e          op_q;    // opcode of the current operation
    logic [char_w-1:0] char_q;  // character of the current operation
    logic [word_w-1:0] cnt_q;   // value to write and to report
    logic [word_w-1:0] sat_inc; // incremented count, sticks at all ones

    assign sat_inc = (mem.rdata == '1) ? mem.rdata : mem.rdata + word_w'(1);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state <= H_IDLE;
        end else begin
            case (state)
                H_IDLE: begin
                    if (hist_valid) begin
                        state <= (hist_op == HOP_CLEAR) ? H_WR : H_RD;  // clear skips the read
                    end
                end
                H_RD: begin
                    if (mem.done) begin
                        state <= (op_q == HOP_COUNT) ? H_WR : H_DONE;
                    end
                end
                H_WR: begin
                    if (mem.done) begin
                        state <= H_DONE;
                    end
                end
                default: state <= H_IDLE;  // H_DONE lasts one cycle
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (hist_valid && hist_ready) begin
            op_q   <= hist_op;
            char_q <= hist_char;
            cnt_q  <= '0;  // clear writes and reports zero
        end else if (state == H_RD && mem.done) begin
            cnt_q <= (op_q == HOP_COUNT) ? sat_inc : mem.rdata;
        end
    end

    assign hist_ready = (state == H_IDLE);
    assign hist_done  = (state == H_DONE);
    assign hist_count = cnt_q;

    // req stays up across the read to write turn, the server ignores it during done
    assign mem.req   = (state == H_RD) || (state == H_WR);
    assign mem.we    = (state == H_WR);
    assign mem.index = char_q;
    assign mem.wdata = cnt_q;

endmodule

//--- src/codebook_store.sv
`timescale 1ns/10ps

module codebook_store import huff_mem_pkg::*; (
    input  logic              clk,
    input  logic              rst,
    input  logic              cb_wr_valid,  // write strobe, wins over trn_valid
    input  logic [char_w-1:0] cb_char,
    input  logic [word_w-1:0] cb_code,
    input  logic              trn_valid,    // translate strobe
    input  logic [char_w-1:0] trn_char,
    output logic              cb_ready,
    output logic              trn_done,     // one cycle, code_word valid
    output logic [word_w-1:0] code_word,
    mem_client_if.client      mem
);

    typedef enum logic [1:0] {
        C_IDLE,  // free
        C_WR,    // storing a code word
        C_RD,    // looking one up
        C_DONE   // translation result out
    } cb_state_e;

    cb_state_e         state;
    logic [char_w-1:0] char_q;   // character in flight
    logic [word_w-1:0] wcode_q;  // code word to store

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state <= C_IDLE;
        end else begin
            case (state)
                C_IDLE: begin
                    if (cb_wr_valid) begin
                        state <= C_WR;
                    end else if (trn_valid) begin
                        state <= C_RD;
                    end
                end
                C_WR:    state <= mem.done ? C_IDLE : C_WR;  // ready comes back next cycle
                C_RD:    state <= mem.done ? C_DONE : C_RD;
                default: state <= C_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (cb_ready && cb_wr_valid) begin
            char_q  <= cb_char;
            wcode_q <= cb_code;
        end else if (cb_ready && trn_valid) begin
            char_q <= trn_char;  // dropped if a write came in the same cycle
        end
        if (state == C_RD && mem.done) begin
            code_word <= mem.rdata;
        end
    end

    assign cb_ready  = (state == C_IDLE);
    assign trn_done  = (state == C_DONE);
    assign mem.req   = (state == C_WR) || (state == C_RD);
    assign mem.we    = (state == C_WR);
    assign mem.index = char_q;
    assign mem.wdata = wcode_q;

endmodule

//--- src/huff_mem_top.sv
`timescale 1ns/10ps

module huff_mem_top import huff_mem_pkg::*; (
    input  logic              clk,
    input  logic              rst,
    // histogram side
    input  logic              hist_valid,
    input  hist_op_e          hist_op,
    input  logic [char_w-1:0] hist_char,
    output logic              hist_ready,
    output logic              hist_done,
    output logic [word_w-1:0] hist_count,
    // codebook write
    input  logic              cb_wr_valid,
    input  logic [char_w-1:0] cb_char,
    input  logic [word_w-1:0] cb_code,
    // translation
    input  logic              trn_valid,
    input  logic [char_w-1:0] trn_char,
    output logic              cb_ready,
    output logic              trn_done,
    output logic [word_w-1:0] code_word
);

    mem_client_if hist_mem ();  // histogram to sequencer
    mem_client_if cb_mem ();    // codebook to sequencer
    sram_bus_if   bus ();       // sequencer to sram

    histogram_counter u_histogram_counter (
        .clk        (clk),
        .rst        (rst),
        .hist_valid (hist_valid),
        .hist_op    (hist_op),
        .hist_char  (hist_char),
        .hist_ready (hist_ready),
        .hist_done  (hist_done),
        .hist_count (hist_count),
        .mem        (hist_mem.client)
    );

    codebook_store u_codebook_store (
        .clk         (clk),
        .rst         (rst),
        .cb_wr_valid (cb_wr_valid),
        .cb_char     (cb_char),
        .cb_code     (cb_code),
        .trn_valid   (trn_valid),
        .trn_char    (trn_char),
        .cb_ready    (cb_ready),
        .trn_done    (trn_done),
        .code_word   (code_word),
        .mem         (cb_mem.client)
    );

    sram_sequencer u_sram_sequencer (
        .clk      (clk),
        .rst      (rst),
        .hist_mem (hist_mem.server),
        .cb_mem   (cb_mem.server),
        .bus      (bus.controller)
    );

    sram_model u_sram_model (
        .clk (clk),
        .rst (rst),
        .bus (bus.memory)
    );

endmodule

//--- testbench/tb_huff_mem.sv
`timescale 1ns/10ps

module tb_huff_mem import huff_mem_pkg::*; ();

    localparam int tab_len  = 64;
    localparam int max_wait = 40;  // cycles, one access is 5 plus arbitration
    localparam int k_hist   = 0;   // histogram op alone
    localparam int k_wr     = 1;   // codebook write alone
    localparam int k_trn    = 2;   // translation alone
    localparam int k_hw     = 3;   // hist op and cb write in one cycle
    localparam int k_ht     = 4;   // hist op and translation in one cycle
    localparam int k_wt     = 5;   // cb write and translation together, write wins

    logic              clk, rst;
    logic              hist_valid, hist_ready, hist_done;
    hist_op_e          hist_op;
    logic [char_w-1:0] hist_char, cb_char, trn_char;
    logic [word_w-1:0] hist_count, cb_code, code_word;
    logic              cb_wr_valid, trn_valid, cb_ready, trn_done;

    // stimulus and expected values, one row per test
    string             t_name  [tab_len];
    int                t_kind  [tab_len];
    hist_op_e          t_op    [tab_len];
    logic [char_w-1:0] t_hch   [tab_len];  // histogram character
    logic [char_w-1:0] t_cch   [tab_len];  // codebook write character
    logic [char_w-1:0] t_tch   [tab_len];  // translation character
    logic [word_w-1:0] t_code  [tab_len];
    logic [word_w-1:0] t_exp_h [tab_len];  // expected hist_count
    logic [word_w-1:0] t_exp_c [tab_len];  // expected code_word
    int                n_ent;

    logic [word_w-1:0] ref_count [256];  // model of the histogram region
    logic [word_w-1:0] ref_code  [256];  // model of the codebook region
    int                err_cnt, n_pass, n_fail, i, err0;

    huff_mem_top u_huff_mem_top (.*);

    initial clk = 1'b0;
    always #5 clk = ~clk;

    task automatic check(input string name, input logic [31:0] exp, input logic [31:0] act);
        if (act !== exp) begin
            $display("ERR %s expected %h actual %h", name, exp, act);
            err_cnt++;
        end
    endtask

    // appends a row, expected values follow the block rules on the model
    task automatic add_entry(input string name, input int kind, input hist_op_e op,
                             input logic [7:0] hch, input logic [7:0] cch,
                             input logic [31:0] code, input logic [7:0] tch);
        t_name[n_ent] = name;
        t_kind[n_ent] = kind;
        t_op[n_ent]   = op;
        t_hch[n_ent]  = hch;
        t_cch[n_ent]  = cch;
        t_tch[n_ent]  = tch;
        t_code[n_ent] = code;
        if (kind == k_hist || kind == k_hw || kind == k_ht) begin
            if (op == HOP_CLEAR) ref_count[hch] = 32'h0;
            else if (op == HOP_COUNT && ref_count[hch] != 32'hffff_ffff)
                ref_count[hch] = ref_count[hch] + 32'd1;  // saturating count
            t_exp_h[n_ent] = ref_count[hch];
        end
        if (kind == k_wr || kind == k_hw || kind == k_wt) ref_code[cch] = code;
        if (kind == k_trn || kind == k_ht) t_exp_c[n_ent] = ref_code[tch];
        n_ent++;
    endtask

    task automatic build_table();
        logic [7:0] pool [6];  // random characters for the mixed run
        int         k;
        n_ent = 0;
        add_entry("clr_41", k_hist, HOP_CLEAR, 8'h41, 8'h00, 32'h0, 8'h00);
        add_entry("clr_42", k_hist, HOP_CLEAR, 8'h42, 8'h00, 32'h0, 8'h00);
        add_entry("clr_05", k_hist, HOP_CLEAR, 8'h05, 8'h00, 32'h0, 8'h00);
        add_entry("clr_7e", k_hist, HOP_CLEAR, 8'h7e, 8'h00, 32'h0, 8'h00);
        add_entry("cnt_41_a", k_hist, HOP_COUNT, 8'h41, 8'h00, 32'h0, 8'h00);
        add_entry("cnt_41_b", k_hist, HOP_COUNT, 8'h41, 8'h00, 32'h0, 8'h00);
        add_entry("cnt_41_c", k_hist, HOP_COUNT, 8'h41, 8'h00, 32'h0, 8'h00);
        add_entry("rd_41", k_hist, HOP_READ, 8'h41, 8'h00, 32'h0, 8'h00);
        add_entry("cnt_42", k_hist, HOP_COUNT, 8'h42, 8'h00, 32'h0, 8'h00);
        add_entry("rd_41_again", k_hist, HOP_READ, 8'h41, 8'h00, 32'h0, 8'h00);
        add_entry("cnt_05", k_hist, HOP_COUNT, 8'h05, 8'h00, 32'h0, 8'h00);
        add_entry("wr_05", k_wr, HOP_READ, 8'h00, 8'h05, 32'hc0de_0005, 8'h00);
        add_entry("trn_05", k_trn, HOP_READ, 8'h00, 8'h00, 32'h0, 8'h05);
        add_entry("rd_05_sep", k_hist, HOP_READ, 8'h05, 8'h00, 32'h0, 8'h00);  // regions apart
        add_entry("wr_7e", k_wr, HOP_READ, 8'h00, 8'h7e, 32'h1234_5678, 8'h00);
        add_entry("trn_7e", k_trn, HOP_READ, 8'h00, 8'h00, 32'h0, 8'h7e);
        add_entry("wr_trn_same", k_wt, HOP_READ, 8'h00, 8'h7e, 32'h8765_4321, 8'h05);
        add_entry("trn_7e_new", k_trn, HOP_READ, 8'h00, 8'h00, 32'h0, 8'h7e);
        add_entry("trn_05_kept", k_trn, HOP_READ, 8'h00, 8'h00, 32'h0, 8'h05);
        for (k = 0; k < 6; k++) begin
            pool[k] = 8'($urandom_range(255, 0));
            add_entry($sformatf("rnd_clr_%0d", k), k_hist, HOP_CLEAR, pool[k], 8'h00,
                      32'h0, 8'h00);
            add_entry($sformatf("rnd_wr_%0d", k), k_wr, HOP_READ, 8'h00, pool[k],
                      $urandom(), 8'h00);
        end
        for (k = 0; k < 16; k++) begin
            add_entry($sformatf("mix_%0d", k), ($urandom_range(1, 0) == 0) ? k_hw : k_ht,
                      hist_op_e'(2'($urandom_range(2, 0))), pool[$urandom_range(5, 0)],
                      pool[$urandom_range(5, 0)], $urandom(), pool[$urandom_range(5, 0)]);
        end
    endtask

    // called at 1 ns after an edge, returns at the same point
    task automatic wait_ready(input string name, input logic need_h, input logic need_c);
        int cyc;
        cyc = 0;
        while (((need_h && !hist_ready) || (need_c && !cb_ready)) && cyc < max_wait) begin
            @(posedge clk);
            #1;
            cyc++;
        end
        if (cyc >= max_wait) begin
            $display("%s gave up, ready stayed low for %0d cycles", name, max_wait);
            err_cnt++;
        end
    endtask

    task automatic run_entry(input int n);
        logic        use_h, use_w, use_t, got_h, got_w, got_t, trn_extra;
        logic [31:0] cnt_got, code_got;
        int          cyc;
        use_h = (t_kind[n] == k_hist || t_kind[n] == k_hw || t_kind[n] == k_ht);
        use_w = (t_kind[n] == k_wr || t_kind[n] == k_hw || t_kind[n] == k_wt);
        use_t = (t_kind[n] == k_trn || t_kind[n] == k_ht || t_kind[n] == k_wt);
        wait_ready(t_name[n], use_h, use_w || use_t);
        hist_valid  = use_h;  // all strobes in the same cycle
        hist_op     = t_op[n];
        hist_char   = t_hch[n];
        cb_wr_valid = use_w;
        cb_char     = t_cch[n];
        cb_code     = t_code[n];
        trn_valid   = use_t;
        trn_char    = t_tch[n];
        @(posedge clk);
        #1;
        hist_valid  = 1'b0;
        cb_wr_valid = 1'b0;
        trn_valid   = 1'b0;
        got_h     = !use_h;
        got_w     = !use_w;
        got_t     = !use_t || (t_kind[n] == k_wt);  // the dropped translation never ends
        trn_extra = 1'b0;
        cnt_got   = 32'h0;
        code_got  = 32'h0;
        cyc       = 0;
        while (!(got_h && got_w && got_t) && cyc < max_wait) begin
            @(posedge clk);
            #1;
            cyc++;
            if (use_h && hist_done) begin
                got_h   = 1'b1;
                cnt_got = hist_count;
            end
            if (trn_done && t_kind[n] == k_wt) trn_extra = 1'b1;
            else if (trn_done) begin
                got_t    = 1'b1;
                code_got = code_word;
            end
            if (use_w && cb_ready) got_w = 1'b1;  // write done when ready comes back
        end
        if (!(got_h && got_w && got_t)) begin
            $display("%s did not finish within %0d cycles", t_name[n], max_wait);
            err_cnt++;
        end else begin
            if (use_h) check({t_name[n], " count"}, t_exp_h[n], cnt_got);
            if (use_t && t_kind[n] != k_wt) check({t_name[n], " code"}, t_exp_c[n], code_got);
            if (t_kind[n] == k_wt) check({t_name[n], " trn_done"}, 32'h0, 32'(trn_extra));
        end
    endtask

    initial begin
        rst         = 1'b1;
        hist_valid  = 1'b0;
        hist_op     = HOP_READ;
        hist_char   = '0;
        cb_wr_valid = 1'b0;
        cb_char     = '0;
        cb_code     = '0;
        trn_valid   = 1'b0;
        trn_char    = '0;
        err_cnt     = 0;
        n_pass      = 0;
        n_fail      = 0;
        void'($urandom(32'h91585d3b));
        build_table();
        repeat (4) @(posedge clk);
        #1;
        rst = 1'b0;
        err0 = err_cnt;
        check("reset hist_ready", 32'h1, 32'(hist_ready));
        check("reset cb_ready", 32'h1, 32'(cb_ready));
        check("reset hist_done", 32'h0, 32'(hist_done));
        check("reset trn_done", 32'h0, 32'(trn_done));
        if (err_cnt == err0) n_pass++;
        else n_fail++;
        $display("%s reset_state", (err_cnt == err0) ? "PASS" : "FAIL");
        for (i = 0; i < n_ent; i++) begin
            err0 = err_cnt;
            run_entry(i);
            if (err_cnt == err0) n_pass++;
            else n_fail++;
            $display("%s %s", (err_cnt == err0) ? "PASS" : "FAIL", t_name[i]);
        end
        $display("tests run %0d, passed %0d, failed %0d, check errors %0d",
                 n_pass + n_fail, n_pass, n_fail, err_cnt);
        if (n_fail == 0 && err_cnt == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

endmodule

//--- verilog.f
src/huff_mem_pkg.sv
src/mem_client_if.sv
src/sram_bus_if.sv
src/sram_model.sv
src/sram_sequencer.sv
src/histogram_counter.sv
src/codebook_store.sv
src/huff_mem_top.sv
testbench/tb_huff_mem.sv

//--- Makefile
all: run

compile: obj_dir/Vtb_huff_mem

obj_dir/Vtb_huff_mem: verilog.f $(wildcard src/*.sv testbench/*.sv)
	verilator --binary --timing --top-module tb_huff_mem -f verilog.f -Mdir obj_dir

run: compile
	./obj_dir/Vtb_huff_mem | tee sim.log
	grep -q "^all tests passed$$" sim.log

clean:
	rm -rf obj_dir sim.log

.PHONY: all compile run clean
